//--- hdl/uartRegPkg.sv
package uartRegPkg;

	////////////////////
	// host register map
	localparam int regAddrLen = 2;

	localparam logic [regAddrLen-1:0] regData   = 2'd0;	// wr pushes tx, rd pops rx
	localparam logic [regAddrLen-1:0] regStatus = 2'd1;	// rd clears sticky flags
	localparam logic [regAddrLen-1:0] regDivLo  = 2'd2;
	localparam logic [regAddrLen-1:0] regDivHi  = 2'd3;

	// baud divisor, tick every divisor+1 clocks
	localparam int divLen = 16;
	localparam logic [divLen-1:0] divReset = 16'd3;

	////////////////////
	// host bus, single-cycle strobe
	typedef struct packed {
		logic strobe;
		logic write;
		logic [regAddrLen-1:0] addr;
		logic [7:0] wdata;
	} busReq_t;

	typedef struct packed {
		logic rdValid;	// one cycle after a read strobe
		logic [7:0] rdata;
	} busRsp_t;

	// status byte, first field is bit 7
	typedef struct packed {
		logic [1:0] rsvd;
		logic overrun;
		logic frameErr;
		logic txFull;
		logic txEmpty;
		logic rxFull;
		logic rxEmpty;
	} status_t;

endpackage

//--- hdl/uartFramePkg.sv
package uartFramePkg;

	////////////////////
	// serial frame, 8N1
	localparam int dataBits = 8;
	localparam int oversample = 16;	// ticks per bit

	////////////////////
	// fifo geometry
	localparam int fifoDepth = 16;
	localparam int fifoAddrLen = 4;	// depth is a power of two, pointers just wrap

	// received byte plus its own framing result
	typedef struct packed {
		logic [dataBits-1:0] data;
		logic frameErr;	// stop bit sampled low
	} rxEntry_t;

endpackage

//--- hdl/baudTickGen.sv
`timescale 1ns/10ps

module baudTickGen import uartRegPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic [divLen-1:0] divisor,
	input  logic restart,
	output logic sTick
);

	logic [divLen-1:0] cntReg;	// counts down to zero

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cntReg <= divReset;
			sTick <= 1'b0;
		end
		else if (restart)
		begin
			cntReg <= divisor;	// new divisor, fresh period
			sTick <= 1'b0;
		end
		else if (cntReg == '0)
		begin
			cntReg <= divisor;	// reload and strobe
			sTick <= 1'b1;
		end
		else
		begin
			cntReg <= cntReg - 1'b1;
			sTick <= 1'b0;
		end
	end

	// divisor 0 is the one case with a tick on every clock
	assert property (@(posedge clk) disable iff (reset)
		sTick && (divisor != '0) |=> !sTick);

endmodule

//--- hdl/uartRec.sv
`timescale 1ns/10ps

module uartRec import uartFramePkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic rx,
	output logic rxDoneTick,
	output rxEntry_t rxEntry
);

	typedef enum logic [1:0] {idle, start, data, stop} state_t;

	state_t stateReg;
	state_t stateNext;
	logic [$clog2(oversample)-1:0] sReg;	// tick counter within a bit
	logic [$clog2(oversample)-1:0] sNext;
	logic [$clog2(dataBits)-1:0] nReg;	// data bit index
	logic [$clog2(dataBits)-1:0] nNext;
	logic [dataBits-1:0] bReg;	// shift register, lsb first
	logic [dataBits-1:0] bNext;
	logic rxMeta;
	logic rxSync;
	logic rxPrev;	// for falling edge detect

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg <= '0;
			nReg <= '0;
			rxMeta <= 1'b1;	// line idles high
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			rxMeta <= rx;	// two-flop sync, rx is async
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////
	// next state logic
	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			idle:
				// edge, not level, so a low stop bit does not restart a frame
				if (rxPrev && !rxSync)
				begin
					stateNext = start;
					sNext = '0;
				end
			start:
				if (sTick)
				begin
					if (sReg == oversample/2 - 1)	// middle of start bit
					begin
						stateNext = rxSync ? idle : data;	// high here is a glitch
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			data:
				if (sTick)
				begin
					if (sReg == oversample - 1)	// middle of next data bit
					begin
						sNext = '0;
						bNext = {rxSync, bReg[dataBits-1:1]};
						if (nReg == dataBits - 1)
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			stop:
				if (sTick)
				begin
					if (sReg == oversample - 1)	// middle of stop bit
					begin
						stateNext = idle;
						rxDoneTick = 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
		endcase
	end

	// frameErr only meaningful beside rxDoneTick
	assign rxEntry = '{data: bReg, frameErr: !rxSync};

	assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |-> (stateReg == stop) && sTick);

	// stop only after the eighth data bit
	assert property (@(posedge clk) disable iff (reset)
		(stateReg == stop) |-> (nReg == dataBits - 1));

endmodule

//--- hdl/uartTrans.sv
`timescale 1ns/10ps

module uartTrans import uartFramePkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic fifoEmpty,
	input  logic [dataBits-1:0] fifoHead,
	output logic pop,
	output logic tx
);

	typedef enum logic [1:0] {idle, start, data, stop} state_t;

	state_t stateReg;
	state_t stateNext;
	logic [$clog2(oversample)-1:0] sReg;
	logic [$clog2(oversample)-1:0] sNext;
	logic [$clog2(dataBits)-1:0] nReg;
	logic [$clog2(dataBits)-1:0] nNext;
	logic [dataBits-1:0] bReg;	// byte being shifted out
	logic [dataBits-1:0] bNext;
	logic txReg;	// registered, glitch free line
	logic txNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		pop = 1'b0;
		case (stateReg)
			idle:
				if (!fifoEmpty)
				begin
					pop = 1'b1;	// take head, show-ahead fifo
					bNext = fifoHead;
					stateNext = start;
					sNext = '0;
				end
			start:
				if (sTick)
				begin
					if (txReg)
						txNext = 1'b0;	// first tick opens start bit
					else if (sReg == oversample - 1)
					begin
						stateNext = data;
						sNext = '0;
						nNext = '0;
						txNext = bReg[0];
					end
					else
						sNext = sReg + 1'b1;
				end
			data:
				if (sTick)
				begin
					if (sReg == oversample - 1)
					begin
						sNext = '0;
						if (nReg == dataBits - 1)
						begin
							stateNext = stop;
							txNext = 1'b1;	// one stop bit
						end
						else
						begin
							nNext = nReg + 1'b1;
							bNext = {1'b0, bReg[dataBits-1:1]};
							txNext = bReg[1];
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			stop:
				if (sTick)
				begin
					if (sReg == oversample - 1)
						stateNext = idle;
					else
						sNext = sReg + 1'b1;
				end
		endcase
	end

	assign tx = txReg;

	// empty flag comes from the fifo
	assert property (@(posedge clk) disable iff (reset) pop |-> !fifoEmpty);

endmodule

//--- hdl/byteFifo.sv
`timescale 1ns/10ps

module byteFifo import uartFramePkg::*;
#(
	parameter type payload_t = logic [7:0]
)
(
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  payload_t pushData,
	input  logic pop,
	output payload_t head,
	output logic empty,
	output logic full
);

	payload_t mem [fifoDepth];
	logic [fifoAddrLen-1:0] wrPtr;
	logic [fifoAddrLen-1:0] rdPtr;
	logic [fifoAddrLen:0] count;	// one extra bit for full
	logic doPush;
	logic doPop;

	assign doPush = push && !full;	// dropped when full
	assign doPop = pop && !empty;	// ignored when empty

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// none, or both at once
			endcase
		end
	end

	assign head = mem[rdPtr];	// show-ahead
	assign empty = (count == '0);
	assign full = (count == fifoDepth);

	assert property (@(posedge clk) disable iff (reset) count <= fifoDepth);

endmodule

//--- hdl/uartCtrlRegs.sv
`timescale 1ns/10ps

module uartCtrlRegs import uartRegPkg::*, uartFramePkg::*;
(
	input  logic clk,
	input  logic reset,
	input  busReq_t hostReq,
	output busRsp_t hostRsp,
	output logic [divLen-1:0] divisor,
	output logic divRestart,
	output logic txPush,
	output logic [dataBits-1:0] txData,
	input  logic txEmpty,
	input  logic txFull,
	input  logic rxDoneTick,
	input  rxEntry_t rxEntry,
	output logic rxPush,
	output logic rxPop,
	input  rxEntry_t rxHead,
	input  logic rxEmpty,
	input  logic rxFull
);

	logic wrHit;
	logic rdHit;
	logic frameErrSticky;
	logic overrunSticky;
	logic rdValidReg;
	logic [7:0] rdataReg;
	logic [7:0] rdataNext;
	status_t status;

	assign wrHit = hostReq.strobe && hostReq.write;
	assign rdHit = hostReq.strobe && !hostReq.write;

	////////////////////
	// fifo steering
	assign txPush = wrHit && (hostReq.addr == regData);	// fifo drops it if full
	assign txData = hostReq.wdata;
	assign rxPop = rdHit && (hostReq.addr == regData) && !rxEmpty;
	assign rxPush = rxDoneTick && !rxFull;

	assign status = '{rsvd: 2'b00, overrun: overrunSticky, frameErr: frameErrSticky,
		txFull: txFull, txEmpty: txEmpty, rxFull: rxFull, rxEmpty: rxEmpty};

	always_comb
	begin
		case (hostReq.addr)
			regData: rdataNext = rxEmpty ? 8'h00 : rxHead.data;	// empty reads 0
			regStatus: rdataNext = status;
			regDivLo: rdataNext = divisor[7:0];
			default: rdataNext = divisor[divLen-1:8];
		endcase
	end

	////////////////////
	// divisor, sticky flags, read handshake
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divisor <= divReset;
			divRestart <= 1'b0;
			frameErrSticky <= 1'b0;
			overrunSticky <= 1'b0;
			rdValidReg <= 1'b0;
		end
		else
		begin
			rdValidReg <= rdHit;
			// one cycle late, so the counter reloads the new value
			divRestart <= wrHit && (hostReq.addr == regDivLo || hostReq.addr == regDivHi);
			if (wrHit && hostReq.addr == regDivLo)
				divisor[7:0] <= hostReq.wdata;
			if (wrHit && hostReq.addr == regDivHi)
				divisor[divLen-1:8] <= hostReq.wdata;
			if (rdHit && hostReq.addr == regStatus)
			begin
				frameErrSticky <= 1'b0;	// read to clear
				overrunSticky <= 1'b0;
			end
			if (rxDoneTick && rxEntry.frameErr)
				frameErrSticky <= 1'b1;	// set wins over clear
			if (rxDoneTick && rxFull)
				overrunSticky <= 1'b1;	// byte lost
		end
	end

	always_ff @(posedge clk)
	begin
		if (rdHit)
			rdataReg <= rdataNext;
	end

	assign hostRsp = '{rdValid: rdValidReg, rdata: rdataReg};

endmodule

//--- hdl/uartTop.sv
`timescale 1ns/10ps

module uartTop import uartRegPkg::*, uartFramePkg::*;
(
	input  logic clk,
	input  logic reset,
	input  busReq_t hostReq,
	output busRsp_t hostRsp,
	input  logic rx,
	output logic tx
);

	logic sTick;
	logic [divLen-1:0] divisor;
	logic divRestart;
	logic rxDoneTick;
	rxEntry_t rxEntry;
	logic txPush;
	logic [dataBits-1:0] txData;
	logic txPop;
	logic [dataBits-1:0] txHead;
	logic txEmpty;
	logic txFull;
	logic rxPush;
	logic rxPop;
	rxEntry_t rxHead;
	logic rxEmpty;
	logic rxFull;

	baudTickGen baudGen (.clk, .reset, .divisor, .restart(divRestart), .sTick);

	uartRec receiver (.clk, .reset, .sTick, .rx, .rxDoneTick, .rxEntry);

	uartTrans transmitter (.clk, .reset, .sTick, .fifoEmpty(txEmpty), .fifoHead(txHead),
		.pop(txPop), .tx);

	////////////////////
	// one fifo per direction
	byteFifo #(.payload_t(logic [dataBits-1:0])) txFifo (.clk, .reset, .push(txPush),
		.pushData(txData), .pop(txPop), .head(txHead), .empty(txEmpty), .full(txFull));

	byteFifo #(.payload_t(rxEntry_t)) rxFifo (.clk, .reset, .push(rxPush),
		.pushData(rxEntry), .pop(rxPop), .head(rxHead), .empty(rxEmpty), .full(rxFull));

	uartCtrlRegs ctrlRegs (.clk, .reset, .hostReq, .hostRsp, .divisor, .divRestart,
		.txPush, .txData, .txEmpty, .txFull, .rxDoneTick, .rxEntry, .rxPush, .rxPop,
		.rxHead, .rxEmpty, .rxFull);

endmodule

//--- verif/tbUart.sv
`timescale 1ns/10ps

module tbUart import uartRegPkg::*, uartFramePkg::*;
();

	localparam int pollLimit = 2000;	// status polls per received byte
	localparam int edgeLimit = 40000;	// clocks to wait for a tx edge

	logic clk;
	logic reset;
	busReq_t hostReq;
	busRsp_t hostRsp;
	logic rx;
	logic tx;
	logic rxDrive;	// serial model output
	logic loopback;	// rx source select

	logic [31:0] lfsr = 32'he6c7;
	logic [7:0] expQ [$];	// expected bytes, in order
	int curDiv = divReset;
	int errCount = 0;
	int checkCount = 0;
	int testCount = 0;

	assign rx = loopback ? tx : rxDrive;

	uartTop u_dut (.clk, .reset, .hostReq, .hostRsp, .rx, .tx);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	////////////////////
	// random source
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		lfsrNext = s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);	// galois, shift right
	endfunction

	task automatic randBits(input int n, output logic [31:0] val);
		val = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsrNext(lfsr);	// one step per bit
			val = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic int bitClocks();
		return oversample * (curDiv + 1);
	endfunction

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
			errCount++;
		end
	endtask

	task automatic endTest(input string name, input int errsBefore);
		testCount++;
		$display("%s: %s", name, (errCount == errsBefore) ? "passed" : "failed");
	endtask

	////////////////////
	// host bus, driven on falling edge
	task automatic driveReq(input logic strobe, input logic write,
		input logic [regAddrLen-1:0] addr, input logic [7:0] wdata);
		hostReq.strobe = strobe;
		hostReq.write = write;
		hostReq.addr = addr;
		hostReq.wdata = wdata;
	endtask

	task automatic writeReg(input logic [regAddrLen-1:0] addr, input logic [7:0] data);
		@(negedge clk);
		driveReq(1'b1, 1'b1, addr, data);
		@(negedge clk);
		driveReq(1'b0, 1'b0, '0, '0);
	endtask

	task automatic readReg(input logic [regAddrLen-1:0] addr, output logic [7:0] data);
		@(negedge clk);
		checkVal("rdValid", hostRsp.rdValid, 0);	// low in strobe cycle
		driveReq(1'b1, 1'b0, addr, '0);
		@(negedge clk);
		checkVal("rdValid", hostRsp.rdValid, 1);	// next cycle only
		data = hostRsp.rdata;
		driveReq(1'b0, 1'b0, '0, '0);
		@(negedge clk);
		checkVal("rdValid", hostRsp.rdValid, 0);
	endtask

	// poll status until a byte sits in the rx fifo
	task automatic waitRxData(output status_t st);
		int polls;
		logic [7:0] d;
		polls = 0;
		readReg(regStatus, d);
		st = d;
		while (st.rxEmpty && polls < pollLimit)
		begin
			readReg(regStatus, d);
			st = d;
			polls++;
		end
		if (st.rxEmpty)
		begin
			$display("timeout: no byte received after %0d status polls at %0t", polls, $time);
			errCount++;
		end
	endtask

	////////////////////
	// serial line model
	task automatic holdBit(input logic value);
		rxDrive = value;
		repeat (bitClocks()) @(negedge clk);
	endtask

	task automatic sendFrame(input logic [7:0] data, input logic stopBit);
		@(negedge clk);
		holdBit(1'b0);	// start
		for (int k = 0; k < dataBits; k++)
			holdBit(data[k]);	// lsb first
		holdBit(stopBit);
		if (!stopBit)
			holdBit(1'b1);	// back to idle before next frame
		rxDrive = 1'b1;
	endtask

	task automatic waitTxFall();
		int n;
		n = 0;
		@(negedge clk);
		while (tx && n < edgeLimit)
		begin
			@(negedge clk);
			n++;
		end
		if (tx)
		begin
			$display("timeout: tx never went low at %0t", $time);
			errCount++;
		end
	endtask

	task automatic measureLow(output int width);
		width = 0;
		while (!tx && width < edgeLimit)
		begin
			width++;
			@(negedge clk);
		end
		if (!tx)
		begin
			$display("timeout: tx stuck low at %0t", $time);
			errCount++;
		end
	endtask

	// ten quiet bit times means the frame is over
	task automatic waitTxIdle();
		int high;
		int n;
		high = 0;
		n = 0;
		while (high < 10 * bitClocks() && n < 60 * bitClocks())
		begin
			@(negedge clk);
			n++;
			high = tx ? high + 1 : 0;
		end
		if (high < 10 * bitClocks())
		begin
			$display("timeout: transmitter never went idle at %0t", $time);
			errCount++;
		end
	endtask

	initial
	begin
		status_t st;
		logic [7:0] d;
		logic [31:0] r;
		logic [7:0] sent [18];
		int errsBefore;
		int width;

		reset = 1'b1;
		hostReq = '0;
		rxDrive = 1'b1;
		loopback = 1'b0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// 1. reset state
		errsBefore = errCount;
		checkVal("tx", tx, 1);
		readReg(regStatus, d);
		checkVal("status", d, 8'h05);	// rxEmpty and txEmpty
		readReg(regDivLo, d);
		checkVal("divLo", d, 3);
		readReg(regDivHi, d);
		checkVal("divHi", d, 0);
		readReg(regData, d);
		checkVal("rx data when empty", d, 0);
		endTest("reset state", errsBefore);

		// 2. loopback data
		errsBefore = errCount;
		loopback = 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			randBits(8, r);
			expQ.push_back(r[7:0]);
			writeReg(regData, r[7:0]);
		end
		while (expQ.size() > 0)
		begin
			waitRxData(st);
			checkVal("frameErr", st.frameErr, 0);
			readReg(regData, d);
			checkVal("rx data", d, expQ.pop_front());
		end
		endTest("loopback data", errsBefore);

		////////////////////
		// 3. baud divisor, start bit width
		errsBefore = errCount;
		loopback = 1'b0;
		randBits(3, r);
		curDiv = r + 1;	// 1..8
		writeReg(regDivLo, curDiv[7:0]);
		writeReg(regDivHi, 8'h00);
		readReg(regDivLo, d);
		checkVal("divLo", d, curDiv);
		randBits(8, r);
		writeReg(regData, r[7:0] | 8'h01);	// bit 0 high ends the start bit cleanly
		waitTxFall();
		measureLow(width);
		checkVal("start bit clocks", width, bitClocks());
		waitTxIdle();
		endTest("baud divisor", errsBefore);

		// 4. framing error
		errsBefore = errCount;
		randBits(8, r);
		sendFrame(r[7:0], 1'b0);	// stop bit low
		waitRxData(st);
		checkVal("frameErr first read", st.frameErr, 1);
		readReg(regStatus, d);
		st = d;
		checkVal("frameErr second read", st.frameErr, 0);
		readReg(regData, d);
		checkVal("rx data", d, r[7:0]);
		endTest("framing error", errsBefore);

		// 5. overrun, one frame too many
		errsBefore = errCount;
		for (int i = 0; i < 17; i++)
		begin
			randBits(8, r);
			if (i < fifoDepth)
				expQ.push_back(r[7:0]);	// 17th is lost
			sendFrame(r[7:0], 1'b1);
		end
		readReg(regStatus, d);
		checkVal("status", d, 8'h26);	// rxFull, txEmpty, overrun
		while (expQ.size() > 0)
		begin
			readReg(regData, d);
			checkVal("rx data", d, expQ.pop_front());
		end
		endTest("overrun", errsBefore);

		////////////////////
		// 6. tx fifo full
		errsBefore = errCount;
		loopback = 1'b1;
		for (int i = 0; i < 18; i++)
		begin
			randBits(8, r);
			sent[i] = r[7:0];
			if (i < 17)
				expQ.push_back(r[7:0]);	// one in the transmitter, 16 queued
		end
		for (int i = 0; i < 18; i++)
		begin
			@(negedge clk);
			driveReq(1'b1, 1'b1, regData, sent[i]);	// back to back
		end
		@(negedge clk);
		driveReq(1'b0, 1'b0, '0, '0);
		readReg(regStatus, d);
		st = d;
		checkVal("txFull", st.txFull, 1);
		while (expQ.size() > 0)
		begin
			waitRxData(st);
			readReg(regData, d);
			checkVal("rx data", d, expQ.pop_front());
		end
		waitTxIdle();
		readReg(regStatus, d);
		checkVal("status", d, 8'h05);	// nothing beyond byte 17
		endTest("tx fifo full", errsBefore);

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- compile.f
hdl/uartRegPkg.sv
hdl/uartFramePkg.sv
hdl/baudTickGen.sv
hdl/uartRec.sv
hdl/uartTrans.sv
hdl/byteFifo.sv
hdl/uartCtrlRegs.sv
hdl/uartTop.sv
verif/tbUart.sv
